// File: src.f
hw/window_pkg.sv
hw/block_walker.sv
hw/fetch_addr_gen.sv
hw/window_store.sv
hw/window_buffer.sv
tests/window_buffer_chk.sv
tests/window_buffer_tb.sv

// File: tests/window_buffer_tb.sv
`timescale 1ns/1ps

module window_buffer_tb;

    localparam int MAX_STALL   = 7;     // 3 random bits per stall
    localparam int TOTAL_LOADS = 12;    // Window loads over all tests
    localparam int LOAD_CYCLES = 51 + window_pkg::WIN_WORDS + MAX_STALL + 4;
    localparam int CYCLE_LIMIT = TOTAL_LOADS * LOAD_CYCLES + 300;

    logic                  clk;
    logic                  reset;
    logic                  start;
    window_pkg::img_dim_t  img_width;
    window_pkg::img_dim_t  img_height;
    window_pkg::chan_cnt_t num_channels;
    window_pkg::pad_t      pad_top;
    window_pkg::pad_t      pad_bottom;
    window_pkg::pad_t      pad_left;
    window_pkg::pad_t      pad_right;
    logic                  ram_re;
    window_pkg::ram_addr_t ram_addr;
    window_pkg::pix_t      ram_dout0;
    window_pkg::pix_t      ram_dout1;
    window_pkg::pix_t      ram_dout2;
    window_pkg::pix_t      ram_dout3;
    window_pkg::win_idx_t  win_row;
    window_pkg::win_idx_t  win_col;
    window_pkg::pix_t      win_data;
    logic                  block_valid;
    logic                  block_ready;
    window_pkg::coord_t    block_row;
    window_pkg::coord_t    block_col;
    window_pkg::group_t    chan_group;
    logic                  last_group;
    logic                  done;
    logic                  busy;

    logic [7:0]  img_tag;
    logic [31:0] lfsr = 32'h7ee9;
    logic        stall_en = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;

    logic                  rd_pend = 1'b0;    // Read accepted on the last rising edge
    window_pkg::ram_addr_t rd_addr = '0;

    window_buffer dut_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .img_width    (img_width),
        .img_height   (img_height),
        .num_channels (num_channels),
        .pad_top      (pad_top),
        .pad_bottom   (pad_bottom),
        .pad_left     (pad_left),
        .pad_right    (pad_right),
        .ram_re       (ram_re),
        .ram_addr     (ram_addr),
        .ram_dout0    (ram_dout0),
        .ram_dout1    (ram_dout1),
        .ram_dout2    (ram_dout2),
        .ram_dout3    (ram_dout3),
        .win_row      (win_row),
        .win_col      (win_col),
        .win_data     (win_data),
        .block_valid  (block_valid),
        .block_ready  (block_ready),
        .block_row    (block_row),
        .block_col    (block_col),
        .chan_group   (chan_group),
        .last_group   (last_group),
        .done         (done),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Tensor RAM content, every byte tied to address, lane or image
    function automatic window_pkg::pix_t ram_word(input int addr, input int lane,
                                                  input logic [7:0] tag);
        return {tag, 8'(addr), 8'(8'h11 * (lane + 1)), 8'(addr) ^ 8'ha5};
    endfunction

    // Four lanes, one cycle read latency
    always @(posedge clk) begin
        rd_pend <= ram_re;
        rd_addr <= ram_addr;
    end

    // Read data ready well before the next rising edge
    always @(negedge clk) begin
        if (rd_pend) begin
            ram_dout0 = ram_word(int'(rd_addr), 0, img_tag);
            ram_dout1 = ram_word(int'(rd_addr), 1, img_tag);
            ram_dout2 = ram_word(int'(rd_addr), 2, img_tag);
            ram_dout3 = ram_word(int'(rd_addr), 3, img_tag);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // Zero in padding, else lane 3-g byte reversed
    function automatic window_pkg::pix_t expected_word(input int r, input int c,
                                                       input int ro, input int co, input int g);
        int               ir;
        int               ic;
        window_pkg::pix_t raw;
        ir = ro + r - int'(pad_top);
        ic = co + c - int'(pad_left);
        if (ir < 0 || ir >= int'(img_height) || ic < 0 || ic >= int'(img_width)) return '0;
        raw = ram_word(ir * int'(img_width) + ic, 3 - g, img_tag);
        return {raw[7:0], raw[15:8], raw[23:16], raw[31:24]};
    endfunction

    task automatic check_pix(input string name, input window_pkg::pix_t got, exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_coord(input string name, input window_pkg::coord_t got, exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_group(input string name, input window_pkg::group_t got, exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    // Called on the falling edge right after start or a transfer
    task automatic wait_valid();
        int n;
        n = 0;
        while (!block_valid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!block_valid) begin
            $display("block_valid never rose within 100 cycles at %0t", $time);
            other_errors++;
        end else if (n != 51) begin
            $display("block_valid rose after %0d cycles instead of 51 at %0t", n, $time);
            other_errors++;
        end
    endtask

    task automatic consume_block(input int ro, input int co, input int g,
                                 input logic is_last, input logic is_final);
        int stall;
        wait_valid();
        check_coord("block_row", block_row, window_pkg::coord_t'(ro));
        check_coord("block_col", block_col, window_pkg::coord_t'(co));
        check_group("chan_group", chan_group, window_pkg::group_t'(g));
        check_bit("last_group", last_group, is_last);
        if (stall_en) begin
            take_bits(3, stall);
            repeat (stall) begin
                @(negedge clk);
                check_bit("block_valid", block_valid, 1'b1);
            end
        end
        for (int r = 0; r < window_pkg::WIN_SIZE; r++) begin
            for (int c = 0; c < window_pkg::WIN_SIZE; c++) begin
                @(negedge clk);
                win_row = window_pkg::win_idx_t'(r);
                win_col = window_pkg::win_idx_t'(c);
                @(posedge clk);
                check_pix($sformatf("win_data[%0d][%0d]", r, c), win_data,
                          expected_word(r, c, ro, co, g));
            end
        end
        @(negedge clk);
        block_ready = 1'b1;
        @(negedge clk);
        block_ready = 1'b0;
        check_bit("done", done, is_final);
        check_bit("busy", busy, !is_final);
    endtask

    // Starts a walk and follows the expected raster order to its end
    task automatic run_image(input int w, input int h, input int ch, input int pt,
                             input int pb, input int pl, input int pr, input logic [7:0] tag);
        int   pw;
        int   ph;
        int   groups;
        int   ro;
        int   co;
        logic row_more;
        logic col_more;
        @(negedge clk);
        img_width    = window_pkg::img_dim_t'(w);
        img_height   = window_pkg::img_dim_t'(h);
        num_channels = window_pkg::chan_cnt_t'(ch);
        pad_top      = window_pkg::pad_t'(pt);
        pad_bottom   = window_pkg::pad_t'(pb);
        pad_left     = window_pkg::pad_t'(pl);
        pad_right    = window_pkg::pad_t'(pr);
        img_tag      = tag;
        start        = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        pw     = w + pl + pr;
        ph     = h + pt + pb;
        groups = (ch + 3) / 4;
        ro     = 0;
        row_more = 1'b1;
        while (row_more) begin
            co       = 0;
            col_more = 1'b1;
            row_more = (ro + 4 < ph - 4);
            while (col_more) begin
                col_more = (co + 4 < pw - 4);
                for (int g = 0; g < groups; g++) begin
                    consume_block(ro, co, g, g == groups - 1,
                                  g == groups - 1 && !col_more && !row_more);
                end
                co += 4;
            end
            ro += 4;
        end
    endtask

    task automatic test_single_block();
        run_image(8, 8, 4, 0, 0, 0, 0, 8'h1a);
    endtask

    task automatic test_padded_two_blocks();
        run_image(10, 6, 4, 1, 1, 1, 1, 8'h2b);
    endtask

    task automatic test_three_groups();
        run_image(8, 8, 9, 0, 0, 0, 0, 8'h3c);
    endtask

    task automatic test_random_stalls();
        stall_en = 1'b1;
        run_image(10, 6, 8, 1, 1, 1, 1, 8'h4d);
        stall_en = 1'b0;
    endtask

    task automatic test_reset_mid_run();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_valid();    // Reset hits while the first block is held
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_bit("busy", busy, 1'b0);
        check_bit("block_valid", block_valid, 1'b0);
        run_image(8, 8, 4, 0, 0, 0, 0, 8'h5e);
    endtask

    initial begin
        int total;
        reset        = 1'b1;
        start        = 1'b0;
        block_ready  = 1'b0;
        img_width    = '0;
        img_height   = '0;
        num_channels = '0;
        pad_top      = '0;
        pad_bottom   = '0;
        pad_left     = '0;
        pad_right    = '0;
        win_row      = '0;
        win_col      = '0;
        ram_dout0    = '0;
        ram_dout1    = '0;
        ram_dout2    = '0;
        ram_dout3    = '0;
        img_tag      = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_single_block();
        test_padded_two_blocks();
        test_three_groups();
        test_random_stalls();
        test_reset_mid_run();

        total = value_errors + other_errors + dut_i.chk_i.fail_count;
        $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errors, other_errors, dut_i.chk_i.fail_count);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tests/window_buffer_chk.sv
`timescale 1ns/1ps

module window_buffer_chk (
    input logic                  clk,
    input logic                  reset,
    input logic                  ram_re,
    input window_pkg::ram_addr_t ram_addr,
    input window_pkg::img_dim_t  img_width,
    input window_pkg::img_dim_t  img_height,
    input logic                  busy,
    input logic                  block_valid,
    input logic                  block_ready,
    input window_pkg::coord_t    block_row,
    input window_pkg::coord_t    block_col,
    input window_pkg::group_t    chan_group,
    input logic                  last_group,
    input logic                  done
);

    int fail_count = 0;    // Read by the testbench at the end

    re_while_busy: assert property (@(posedge clk) disable iff (reset) ram_re |-> busy)
        else begin
            fail_count++;
            $error("ram_re high while not busy");
        end

    // Valid and tags hold under back-pressure
    valid_hold: assert property (@(posedge clk) disable iff (reset)
        block_valid && !block_ready |=> block_valid && $stable(block_row)
            && $stable(block_col) && $stable(chan_group) && $stable(last_group))
        else begin
            fail_count++;
            $error("block_valid or its tags changed before block_ready");
        end

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |-> !block_valid ##1 !done)
        else begin
            fail_count++;
            $error("done longer than one cycle or together with block_valid");
        end

    addr_range: assert property (@(posedge clk) disable iff (reset)
        ram_re |-> int'(ram_addr) < int'(img_width) * int'(img_height))
        else begin
            fail_count++;
            $error("ram_addr outside the image");
        end

endmodule

bind window_buffer window_buffer_chk chk_i (
    .clk         (clk),
    .reset       (reset),
    .ram_re      (ram_re),
    .ram_addr    (ram_addr),
    .img_width   (img_width),
    .img_height  (img_height),
    .busy        (busy),
    .block_valid (block_valid),
    .block_ready (block_ready),
    .block_row   (block_row),
    .block_col   (block_col),
    .chan_group  (chan_group),
    .last_group  (last_group),
    .done        (done)
);

// File: hw/window_buffer.sv
`timescale 1ns/1ps

module window_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  window_pkg::img_dim_t  img_width,
    input  window_pkg::img_dim_t  img_height,
    input  window_pkg::chan_cnt_t num_channels,
    input  window_pkg::pad_t      pad_top,
    input  window_pkg::pad_t      pad_bottom,
    input  window_pkg::pad_t      pad_left,
    input  window_pkg::pad_t      pad_right,
    output logic                  ram_re,
    output window_pkg::ram_addr_t ram_addr,
    input  window_pkg::pix_t      ram_dout0,
    input  window_pkg::pix_t      ram_dout1,
    input  window_pkg::pix_t      ram_dout2,
    input  window_pkg::pix_t      ram_dout3,
    input  window_pkg::win_idx_t  win_row,
    input  window_pkg::win_idx_t  win_col,
    output window_pkg::pix_t      win_data,
    output logic                  block_valid,
    input  logic                  block_ready,
    output window_pkg::coord_t    block_row,
    output window_pkg::coord_t    block_col,
    output window_pkg::group_t    chan_group,
    output logic                  last_group,
    output logic                  done,
    output logic                  busy
);

    // Walker to fetch handshake
    logic                 load_start;
    logic                 load_done;

    // Fetch to store write stream
    logic                 wr_en;
    window_pkg::win_idx_t wr_row;
    window_pkg::win_idx_t wr_col;
    logic                 wr_pad;

    block_walker walker_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .img_width    (img_width),
        .img_height   (img_height),
        .num_channels (num_channels),
        .pad_top      (pad_top),
        .pad_bottom   (pad_bottom),
        .pad_left     (pad_left),
        .pad_right    (pad_right),
        .block_ready  (block_ready),
        .load_done    (load_done),
        .load_start   (load_start),
        .block_valid  (block_valid),
        .block_row    (block_row),
        .block_col    (block_col),
        .chan_group   (chan_group),
        .last_group   (last_group),
        .done         (done),
        .busy         (busy)
    );

    fetch_addr_gen fetch_i (
        .clk        (clk),
        .reset      (reset),
        .load_start (load_start),
        .block_row  (block_row),
        .block_col  (block_col),
        .img_width  (img_width),
        .img_height (img_height),
        .pad_top    (pad_top),
        .pad_left   (pad_left),
        .ram_re     (ram_re),
        .ram_addr   (ram_addr),
        .wr_en      (wr_en),
        .wr_row     (wr_row),
        .wr_col     (wr_col),
        .wr_pad     (wr_pad),
        .load_done  (load_done)
    );

    window_store store_i (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_row     (wr_row),
        .wr_col     (wr_col),
        .wr_pad     (wr_pad),
        .chan_group (chan_group),
        .ram_dout0  (ram_dout0),
        .ram_dout1  (ram_dout1),
        .ram_dout2  (ram_dout2),
        .ram_dout3  (ram_dout3),
        .win_row    (win_row),
        .win_col    (win_col),
        .win_data   (win_data)
    );

endmodule

// File: hw/window_store.sv
`timescale 1ns/1ps

module window_store (
    input  logic                 clk,
    input  logic                 wr_en,
    input  window_pkg::win_idx_t wr_row,
    input  window_pkg::win_idx_t wr_col,
    input  logic                 wr_pad,
    input  window_pkg::group_t   chan_group,
    input  window_pkg::pix_t     ram_dout0,
    input  window_pkg::pix_t     ram_dout1,
    input  window_pkg::pix_t     ram_dout2,
    input  window_pkg::pix_t     ram_dout3,
    input  window_pkg::win_idx_t win_row,
    input  window_pkg::win_idx_t win_col,
    output window_pkg::pix_t     win_data
);

    localparam int IDX_W = $clog2(window_pkg::WIN_WORDS);

    window_pkg::pix_t     mem [window_pkg::WIN_WORDS];
    window_pkg::pix_t     lanes [window_pkg::LANES];

    // Issue side delayed to line up with the RAM read data
    logic                 wr_en_q;
    window_pkg::win_idx_t wr_row_q;
    window_pkg::win_idx_t wr_col_q;
    logic                 wr_pad_q;
    window_pkg::group_t   group_q;

    window_pkg::group_t   lane_sel;
    window_pkg::pix_t     lane_word;
    window_pkg::pix_t     rev_word;
    logic [IDX_W-1:0]     wr_idx;
    logic [IDX_W-1:0]     rd_idx;

    always_ff @(posedge clk) begin
        wr_en_q  <= wr_en;
        wr_row_q <= wr_row;
        wr_col_q <= wr_col;
        wr_pad_q <= wr_pad;
        group_q  <= chan_group;
    end

    assign lanes[0] = ram_dout0;
    assign lanes[1] = ram_dout1;
    assign lanes[2] = ram_dout2;
    assign lanes[3] = ram_dout3;

    // Group 0 lives in the top lane
    assign lane_sel  = window_pkg::group_t'(window_pkg::LANES - 1) - group_q;
    assign lane_word = lanes[lane_sel];

    // RAM byte order is the reverse of the channel order
    always_comb begin
        for (int b = 0; b < window_pkg::LANES; b++) begin
            rev_word[8*b +: 8] = lane_word[8*(window_pkg::LANES-1-b) +: 8];
        end
    end

    assign wr_idx = IDX_W'(wr_row_q) * IDX_W'(window_pkg::WIN_SIZE) + IDX_W'(wr_col_q);
    assign rd_idx = IDX_W'(win_row) * IDX_W'(window_pkg::WIN_SIZE) + IDX_W'(win_col);

    always_ff @(posedge clk) begin
        if (wr_en_q) begin
            mem[wr_idx] <= wr_pad_q ? '0 : rev_word;
        end
    end

    assign win_data = mem[rd_idx];    // Combinational read port

endmodule

// File: hw/fetch_addr_gen.sv
`timescale 1ns/1ps

module fetch_addr_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_start,
    input  window_pkg::coord_t      block_row,
    input  window_pkg::coord_t      block_col,
    input  window_pkg::img_dim_t    img_width,
    input  window_pkg::img_dim_t    img_height,
    input  window_pkg::pad_t        pad_top,
    input  window_pkg::pad_t        pad_left,
    output logic                    ram_re,
    output window_pkg::ram_addr_t   ram_addr,
    output logic                    wr_en,
    output window_pkg::win_idx_t    wr_row,
    output window_pkg::win_idx_t    wr_col,
    output logic                    wr_pad,
    output logic                    load_done
);

    logic                 active;
    window_pkg::win_idx_t row;
    window_pkg::win_idx_t col;

    window_pkg::coord_t   pad_row;    // Position in padded space
    window_pkg::coord_t   pad_col;
    window_pkg::coord_t   img_row;    // Position in the image
    window_pkg::coord_t   img_col;
    logic                 in_row;
    logic                 in_col;

    // One window position per cycle, raster order
    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            row       <= '0;
            col       <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (load_start) begin
                active <= 1'b1;
                row    <= '0;
                col    <= '0;
            end else if (active) begin
                if (col == window_pkg::win_idx_t'(window_pkg::WIN_SIZE - 1)) begin
                    col <= '0;
                    if (row == window_pkg::win_idx_t'(window_pkg::WIN_SIZE - 1)) begin
                        active    <= 1'b0;
                        load_done <= 1'b1;    // Cycle after the last issue
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    assign pad_row = block_row + window_pkg::coord_t'(row);
    assign pad_col = block_col + window_pkg::coord_t'(col);

    // Past the padded edge is also past the image, so one test per side suffices
    assign in_row = (pad_row >= window_pkg::coord_t'(pad_top))
                 && (pad_row < window_pkg::coord_t'(pad_top) + window_pkg::coord_t'(img_height));
    assign in_col = (pad_col >= window_pkg::coord_t'(pad_left))
                 && (pad_col < window_pkg::coord_t'(pad_left) + window_pkg::coord_t'(img_width));

    assign img_row = pad_row - window_pkg::coord_t'(pad_top);
    assign img_col = pad_col - window_pkg::coord_t'(pad_left);

    assign ram_addr = window_pkg::ram_addr_t'(img_row) * window_pkg::ram_addr_t'(img_width)
                    + window_pkg::ram_addr_t'(img_col);

    assign wr_en  = active;
    assign wr_row = row;
    assign wr_col = col;
    assign wr_pad = !(in_row && in_col);
    assign ram_re = active && in_row && in_col;    // Padding never touches the RAM

endmodule

// File: hw/block_walker.sv
`timescale 1ns/1ps

module block_walker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  window_pkg::img_dim_t  img_width,
    input  window_pkg::img_dim_t  img_height,
    input  window_pkg::chan_cnt_t num_channels,
    input  window_pkg::pad_t      pad_top,
    input  window_pkg::pad_t      pad_bottom,
    input  window_pkg::pad_t      pad_left,
    input  window_pkg::pad_t      pad_right,
    input  logic                  block_ready,
    input  logic                  load_done,
    output logic                  load_start,
    output logic                  block_valid,
    output window_pkg::coord_t    block_row,
    output window_pkg::coord_t    block_col,
    output window_pkg::group_t    chan_group,
    output logic                  last_group,
    output logic                  done,
    output logic                  busy
);

    window_pkg::walk_state_t state;

    window_pkg::coord_t pad_w;
    window_pkg::coord_t pad_h;
    window_pkg::coord_t next_col;
    window_pkg::coord_t next_row;
    logic [2:0]         num_groups;    // 1 to 4 groups
    logic               col_adv;
    logic               row_adv;

    // Padded image size
    assign pad_w = window_pkg::coord_t'(img_width) + window_pkg::coord_t'(pad_left)
                 + window_pkg::coord_t'(pad_right);
    assign pad_h = window_pkg::coord_t'(img_height) + window_pkg::coord_t'(pad_top)
                 + window_pkg::coord_t'(pad_bottom);

    // Ceiling of channels over lanes
    assign num_groups = 3'((num_channels + window_pkg::chan_cnt_t'(window_pkg::LANES - 1))
                           / window_pkg::LANES);
    assign last_group = (chan_group == window_pkg::group_t'(num_groups - 3'd1));

    // Next origins and whether they still leave room for a block
    assign next_col = block_col + window_pkg::coord_t'(window_pkg::BLOCK_STRIDE);
    assign next_row = block_row + window_pkg::coord_t'(window_pkg::BLOCK_STRIDE);
    assign col_adv  = next_col < (pad_w - window_pkg::coord_t'(window_pkg::BLOCK_STRIDE));
    assign row_adv  = next_row < (pad_h - window_pkg::coord_t'(window_pkg::BLOCK_STRIDE));

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= window_pkg::IDLE;
            block_row  <= '0;
            block_col  <= '0;
            chan_group <= '0;
            load_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            load_start <= 1'b0;    // Both are single cycle pulses
            done       <= 1'b0;
            case (state)
                window_pkg::IDLE: begin
                    if (start) begin
                        block_row  <= '0;
                        block_col  <= '0;
                        chan_group <= '0;
                        load_start <= 1'b1;
                        state      <= window_pkg::LOAD;
                    end
                end
                window_pkg::LOAD: begin
                    if (load_done) state <= window_pkg::HOLD;
                end
                window_pkg::HOLD: begin
                    if (block_ready) begin
                        if (!last_group) begin
                            chan_group <= chan_group + 1'b1;    // Same origin, next group
                            load_start <= 1'b1;
                            state      <= window_pkg::LOAD;
                        end else if (col_adv) begin
                            chan_group <= '0;
                            block_col  <= next_col;
                            load_start <= 1'b1;
                            state      <= window_pkg::LOAD;
                        end else if (row_adv) begin
                            // Wrap to the start of the next block row
                            chan_group <= '0;
                            block_col  <= '0;
                            block_row  <= next_row;
                            load_start <= 1'b1;
                            state      <= window_pkg::LOAD;
                        end else begin
                            chan_group <= '0;
                            done       <= 1'b1;    // Walk finished
                            state      <= window_pkg::IDLE;
                        end
                    end
                end
                default: state <= window_pkg::IDLE;
            endcase
        end
    end

    assign block_valid = (state == window_pkg::HOLD);
    assign busy        = (state != window_pkg::IDLE);

endmodule

// File: hw/window_pkg.sv
package window_pkg;

    // Image and window limits
    localparam int MAX_IMG_DIM  = 16;
    localparam int MAX_PAD      = 3;
    localparam int MAX_CHANNELS = 16;

    localparam int WIN_SIZE     = 7;     // Window edge in pixels
    localparam int BLOCK_STRIDE = 4;     // Origin step between blocks
    localparam int LANES        = 4;     // RAM lanes, also channels per group
    localparam int WIN_WORDS    = WIN_SIZE * WIN_SIZE;

    // 4 channels of 8 bits per word
    typedef logic [8*LANES-1:0] pix_t;

    typedef logic [$clog2(MAX_IMG_DIM+1)-1:0] img_dim_t;
    typedef logic [$clog2(MAX_PAD+1)-1:0] pad_t;
    typedef logic [$clog2(MAX_CHANNELS+1)-1:0] chan_cnt_t;
    typedef logic [$clog2(MAX_CHANNELS/LANES)-1:0] group_t;

    // Row or column inside the window
    typedef logic [$clog2(WIN_SIZE)-1:0] win_idx_t;

    // Padded space coordinate, padded size tops out at 22
    typedef logic [$clog2(MAX_IMG_DIM+2*MAX_PAD+1)-1:0] coord_t;

    // row * width + column
    typedef logic [$clog2(MAX_IMG_DIM*MAX_IMG_DIM)-1:0] ram_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        HOLD
    } walk_state_t;

endpackage
